/* Bender.yml */
package:
  name: exu

sources:
  - common/exu_pkg.sv
  - alu/exu_alu.sv
  - muldiv/exu_mul.sv
  - muldiv/exu_div.sv
  - verilog/exu_writeback.sv
  - verilog/exu_top.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/exu_tb.sv

/* alu/exu_alu.sv */
module exu_alu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    input  exu_pkg::exu_issue_t  issue,
    output logic                 hold_valid,
    output exu_pkg::exu_result_t hold,
    input  logic                 grant,
    output logic                 stalled
);

    logic                     accept;
    logic [exu_pkg::xlen-1:0] opa;      // word ops see sign-extended low half
    logic [exu_pkg::xlen-1:0] opb;
    logic [exu_pkg::xlen-1:0] opa_zx;   // zero-extended form for srl
    logic [5:0]               shamt;
    logic                     eq;
    logic                     lt_s;
    logic                     lt_u;
    logic [exu_pkg::xlen-1:0] res;
    logic                     flag;
    exu_pkg::exu_result_t     res_next;

    assign accept = issue_valid && (issue.unit == exu_pkg::unit_alu);

    assign opa    = issue.word ? {{32{issue.src1[31]}}, issue.src1[31:0]} : issue.src1;
    assign opb    = issue.word ? {{32{issue.src2[31]}}, issue.src2[31:0]} : issue.src2;
    assign opa_zx = issue.word ? {32'd0, issue.src1[31:0]} : issue.src1;
    assign shamt  = issue.word ? {1'b0, issue.src2[4:0]} : issue.src2[5:0];

    assign eq   = (opa == opb);
    assign lt_s = ($signed(opa) < $signed(opb));
    assign lt_u = (opa < opb);

    always_comb begin
        res  = '0;
        flag = 1'b0;
        case (issue.op)
            exu_pkg::op_add:  res = opa + opb;
            exu_pkg::op_sub:  res = opa - opb;
            exu_pkg::op_sll:  res = opa << shamt;
            exu_pkg::op_srl:  res = opa_zx >> shamt;
            exu_pkg::op_sra:  res = $signed(opa) >>> shamt;
            exu_pkg::op_and:  res = opa & opb;
            exu_pkg::op_or:   res = opa | opb;
            exu_pkg::op_xor:  res = opa ^ opb;
            exu_pkg::op_slt:  res[0] = lt_s;   // 0 or 1
            exu_pkg::op_sltu: res[0] = lt_u;
            exu_pkg::op_beq:  flag = eq;       // branches leave data at zero
            exu_pkg::op_bne:  flag = !eq;
            exu_pkg::op_blt:  flag = lt_s;
            exu_pkg::op_bge:  flag = !lt_s;
            exu_pkg::op_bltu: flag = lt_u;
            exu_pkg::op_bgeu: flag = !lt_u;
            default: begin
                res  = '0;
                flag = 1'b0;
            end
        endcase
    end

    always_comb begin
        res_next.tag  = issue.tag;
        res_next.data = issue.word ? {{32{res[31]}}, res[31:0]} : res;
        res_next.flag = flag;
    end

    // a new result may land in the same cycle the old one is granted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (accept) begin
            hold_valid <= 1'b1;
        end else if (grant) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hold <= res_next;
        end
    end

    assign stalled = hold_valid && !grant;   // lost the bus this cycle

endmodule

/* common/exu_pkg.sv */
package exu_pkg;

    localparam int xlen  = 64;
    localparam int tag_w = 4;

    typedef enum logic [1:0] {
        unit_alu,
        unit_mul,
        unit_div
    } exu_unit_e;

    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_sll,
        op_srl,
        op_sra,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_sltu,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        op_mul,   // low 64 bits only
        op_div,
        op_divu,
        op_rem,
        op_remu
    } exu_op_e;

    typedef struct packed {
        exu_unit_e        unit;   // target unit
        exu_op_e          op;
        logic             word;   // 32-bit op, sign-extended result
        logic [xlen-1:0]  src1;
        logic [xlen-1:0]  src2;
        logic [tag_w-1:0] tag;
    } exu_issue_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
        logic             flag;   // branch taken
    } exu_result_t;

endpackage

/* flist.f */
+incdir+tests
common/exu_pkg.sv
alu/exu_alu.sv
muldiv/exu_mul.sv
muldiv/exu_div.sv
verilog/exu_writeback.sv
verilog/exu_top.sv
tests/exu_tb.sv

/* muldiv/exu_div.sv */
module exu_div (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    input  exu_pkg::exu_issue_t  issue,
    output logic                 hold_valid,
    output exu_pkg::exu_result_t hold,
    output logic                 busy,
    input  logic                 grant
);

    typedef enum logic [2:0] {
        idle,
        prep,
        iter,
        fix,
        done
    } div_state_e;

    div_state_e                state;
    logic                      accept;
    logic                      signed_in;
    logic [exu_pkg::xlen-1:0]  a_ext;
    logic [exu_pkg::xlen-1:0]  b_ext;
    logic [5:0]                cnt;
    logic [exu_pkg::xlen-1:0]  a_q;     // extended dividend, kept for x/0
    logic [exu_pkg::xlen-1:0]  dvs;
    logic [exu_pkg::xlen-1:0]  quo;
    logic [exu_pkg::xlen-1:0]  rem;
    logic                      is_signed;
    logic                      is_rem;
    logic                      word;
    logic                      div_zero;
    logic                      neg_q;
    logic                      neg_r;
    logic [exu_pkg::tag_w-1:0] tag_q;
    logic [exu_pkg::xlen:0]    shifted;
    logic [exu_pkg::xlen:0]    trial;
    logic                      take;
    logic [exu_pkg::xlen-1:0]  q_fin;
    logic [exu_pkg::xlen-1:0]  r_fin;
    logic [exu_pkg::xlen-1:0]  res_fin;

    assign accept    = issue_valid && (issue.unit == exu_pkg::unit_div) && (state == idle);
    assign signed_in = (issue.op == exu_pkg::op_div) || (issue.op == exu_pkg::op_rem);

    always_comb begin
        if (!issue.word) begin
            a_ext = issue.src1;
            b_ext = issue.src2;
        end else if (signed_in) begin
            a_ext = {{32{issue.src1[31]}}, issue.src1[31:0]};
            b_ext = {{32{issue.src2[31]}}, issue.src2[31:0]};
        end else begin
            a_ext = {32'd0, issue.src1[31:0]};
            b_ext = {32'd0, issue.src2[31:0]};
        end
    end

    // one restoring step
    assign shifted = {rem, quo[exu_pkg::xlen-1]};
    assign trial   = shifted - {1'b0, dvs};
    assign take    = !trial[exu_pkg::xlen];

    // overflow (min / -1) falls out of the magnitude path unchanged
    assign q_fin   = div_zero ? '1 : (neg_q ? -quo : quo);
    assign r_fin   = div_zero ? a_q : (neg_r ? -rem : rem);
    assign res_fin = is_rem ? r_fin : q_fin;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                idle: if (accept) state <= prep;
                prep: begin
                    state <= iter;
                    cnt   <= '0;
                end
                iter: begin
                    cnt <= cnt + 6'd1;
                    if (cnt == 6'd63) state <= fix;
                end
                fix:  state <= done;
                done: if (grant) state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (accept) begin
                    a_q       <= a_ext;
                    dvs       <= b_ext;
                    is_signed <= signed_in;
                    is_rem    <= (issue.op == exu_pkg::op_rem) || (issue.op == exu_pkg::op_remu);
                    word      <= issue.word;
                    tag_q     <= issue.tag;
                end
            end
            prep: begin
                quo      <= (is_signed && a_q[63]) ? -a_q : a_q;   // magnitudes
                dvs      <= (is_signed && dvs[63]) ? -dvs : dvs;
                rem      <= '0;
                div_zero <= (dvs == '0);
                neg_q    <= is_signed && (a_q[63] ^ dvs[63]);
                neg_r    <= is_signed && a_q[63];
            end
            iter: begin
                quo <= {quo[exu_pkg::xlen-2:0], take};
                rem <= take ? trial[exu_pkg::xlen-1:0] : shifted[exu_pkg::xlen-1:0];
            end
            fix: begin
                hold.tag  <= tag_q;
                hold.data <= word ? {{32{res_fin[31]}}, res_fin[31:0]} : res_fin;
                hold.flag <= 1'b0;
            end
            default: ;
        endcase
    end

    assign busy       = (state != idle);
    assign hold_valid = (state == done);

endmodule

/* muldiv/exu_mul.sv */
module exu_mul #(
    parameter int mul_stages = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    input  exu_pkg::exu_issue_t  issue,
    output logic                 hold_valid,
    output exu_pkg::exu_result_t hold,
    input  logic                 grant
);

    logic                                  accept;
    logic [exu_pkg::xlen-1:0]              prod;
    exu_pkg::exu_result_t                  res_in;
    logic [mul_stages:0]                   chain_v;     // bit 0 is the issue side
    exu_pkg::exu_result_t [mul_stages:0]   chain_res;
    logic [mul_stages-1:0]                 st_v;
    exu_pkg::exu_result_t [mul_stages-1:0] st_res;      // top entry is the hold

    assign accept = issue_valid && (issue.unit == exu_pkg::unit_mul);
    assign prod   = issue.src1 * issue.src2;   // low 64 bits kept

    always_comb begin
        res_in.tag  = issue.tag;
        res_in.data = issue.word ? {{32{prod[31]}}, prod[31:0]} : prod;
        res_in.flag = 1'b0;
    end

    assign chain_v   = {st_v, accept};
    assign chain_res = {st_res, res_in};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_v <= '0;
        end else begin
            for (int i = 0; i < mul_stages - 1; i++) begin
                st_v[i] <= chain_v[i];
            end
            // last stage holds until granted
            st_v[mul_stages-1] <= chain_v[mul_stages-1] | (st_v[mul_stages-1] & ~grant);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < mul_stages; i++) begin
            if (chain_v[i]) begin
                st_res[i] <= chain_res[i];
            end
        end
    end

    assign hold_valid = chain_v[mul_stages];
    assign hold       = chain_res[mul_stages];

endmodule

/* tests/exu_model.svh */
`ifndef exu_model_svh
`define exu_model_svh

function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
endfunction

// expected result and flag, computed on widened operands
function automatic exu_pkg::exu_result_t expect_result(input exu_pkg::exu_issue_t x);
    exu_pkg::exu_result_t e;
    logic                 zx;
    logic [63:0]          a;
    logic [63:0]          b;
    logic [5:0]           sh;
    logic [63:0]          r;
    logic [63:0]          most_neg;
    most_neg = 64'h8000_0000_0000_0000;
    zx = (x.op == exu_pkg::op_srl) || (x.op == exu_pkg::op_divu) || (x.op == exu_pkg::op_remu);
    a  = !x.word ? x.src1 : (zx ? {32'd0, x.src1[31:0]} : sext32(x.src1[31:0]));
    b  = !x.word ? x.src2 : (zx ? {32'd0, x.src2[31:0]} : sext32(x.src2[31:0]));
    sh = x.word ? {1'b0, x.src2[4:0]} : x.src2[5:0];   // 5 or 6 bit shift amount
    r  = '0;
    e.tag  = x.tag;
    e.flag = 1'b0;
    case (x.op)
        exu_pkg::op_add:  r = a + b;
        exu_pkg::op_sub:  r = a - b;
        exu_pkg::op_sll:  r = a << sh;
        exu_pkg::op_srl:  r = a >> sh;
        exu_pkg::op_sra:  r = $signed(a) >>> sh;
        exu_pkg::op_and:  r = a & b;
        exu_pkg::op_or:   r = a | b;
        exu_pkg::op_xor:  r = a ^ b;
        exu_pkg::op_slt:  r[0] = $signed(a) < $signed(b);
        exu_pkg::op_sltu: r[0] = a < b;
        exu_pkg::op_beq:  e.flag = (a == b);
        exu_pkg::op_bne:  e.flag = (a != b);
        exu_pkg::op_blt:  e.flag = $signed(a) < $signed(b);
        exu_pkg::op_bge:  e.flag = $signed(a) >= $signed(b);
        exu_pkg::op_bltu: e.flag = a < b;
        exu_pkg::op_bgeu: e.flag = a >= b;
        exu_pkg::op_mul:  r = a * b;
        exu_pkg::op_div: begin
            if (b == '0) r = '1;                                // divide by zero
            else if (a == most_neg && b == '1) r = a;           // signed overflow
            else r = $signed(a) / $signed(b);
        end
        exu_pkg::op_divu: r = (b == '0) ? '1 : a / b;
        exu_pkg::op_rem: begin
            if (b == '0) r = a;
            else if (a == most_neg && b == '1) r = '0;
            else r = $signed(a) % $signed(b);
        end
        exu_pkg::op_remu: r = (b == '0) ? a : a % b;
        default:          r = '0;
    endcase
    e.data = x.word ? sext32(r[31:0]) : r;
    return e;
endfunction

`endif

/* tests/exu_tb.sv */
module exu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    `include "exu_model.svh"

    localparam int n_tags   = 1 << exu_pkg::tag_w;
    localparam int n_random = 48;
    localparam logic [63:0] min64 = 64'h8000_0000_0000_0000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 issue_valid;
    exu_pkg::exu_issue_t  issue;
    logic                 issue_ready;
    logic                 result_valid;
    exu_pkg::exu_result_t result;

    logic [31:0]          lfsr = 32'hea6b_6a08;
    exu_pkg::exu_result_t expected [n_tags];
    bit                   pending [n_tags];
    string                test_name [n_tags];
    logic [exu_pkg::tag_w-1:0] next_tag = '0;
    logic [exu_pkg::tag_w-1:0] div_tag = '0;
    logic                 div_pending = 1'b0;
    int                   errors = 0;
    int                   accepted = 0;
    int                   retired = 0;
    int                   outstanding = 0;
    int                   cycles = 0;
    int                   limit = 200;   // grows with every issued op

    exu_top #(
        .mul_stages (2)
    ) UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .result_valid (result_valid),
        .result       (result)
    );

    always #10 clk = ~clk;

    // taps 32, 22, 2, 1; one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[62:0], fb};
        end
        return v;
    endfunction

    // follow = presented in the cycle right after the previous op
    task automatic send_op(input exu_pkg::exu_op_e op, input logic word, input logic [63:0] a,
                           input logic [63:0] b, input string name, input logic follow);
        exu_pkg::exu_issue_t x;
        if (!follow) begin
            @(posedge clk);
            issue_valid <= 1'b0;
            @(negedge clk);
            while (!issue_ready || pending[next_tag]) begin
                @(negedge clk);
            end
        end
        if (op == exu_pkg::op_mul) begin
            x.unit = exu_pkg::unit_mul;
        end else if (op >= exu_pkg::op_div) begin
            x.unit = exu_pkg::unit_div;
        end else begin
            x.unit = exu_pkg::unit_alu;
        end
        x.op   = op;
        x.word = word;
        x.src1 = a;
        x.src2 = b;
        x.tag  = next_tag;
        @(posedge clk);
        issue_valid <= 1'b1;
        issue       <= x;
        expected[x.tag]  = expect_result(x);
        test_name[x.tag] = name;
        pending[x.tag]   = 1'b1;
        outstanding++;
        limit    = limit + ((x.unit == exu_pkg::unit_div) ? 70 : 4);
        next_tag = next_tag + 1'b1;   // tags in rotation
        @(negedge clk);
        assert (issue_ready) else begin
            $display("%s was presented while issue_ready was low", name);
            errors++;
        end
    endtask

    task automatic check_result(input exu_pkg::exu_result_t r);
        assert (pending[r.tag]) else begin
            $display("result with tag %0d arrived but nothing with that tag was outstanding",
                     r.tag);
            errors++;
        end
        if (pending[r.tag]) begin
            assert (r.data === expected[r.tag].data) else begin
                $display("** Error %s: expected data %h, actual %h", test_name[r.tag],
                         expected[r.tag].data, r.data);
                errors++;
            end
            assert (r.flag === expected[r.tag].flag) else begin
                $display("** Error %s: expected flag %b, actual %b", test_name[r.tag],
                         expected[r.tag].flag, r.flag);
                errors++;
            end
            pending[r.tag] = 1'b0;
            outstanding--;
            retired++;
            if (div_pending && r.tag == div_tag) begin
                div_pending <= 1'b0;
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && issue_valid && issue_ready) begin
            accepted <= accepted + 1;
            if (issue.unit == exu_pkg::unit_div) begin
                div_pending <= 1'b1;
                div_tag     <= issue.tag;
            end
        end
    end

    // results and ready sampled mid-cycle
    always @(negedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, %0d operations never retired", cycles,
                     outstanding);
            $display("Done: errors found");
            $finish;
        end else if (rst_n) begin
            if (div_pending) begin
                assert (!issue_ready) else begin
                    $display("issue_ready was high while a divide was in flight");
                    errors++;
                end
            end
            if (result_valid) begin
                check_result(result);
            end
        end
    end

    initial begin
        int               i;
        logic [4:0]       code;
        exu_pkg::exu_op_e op;
        logic             word;
        logic [63:0]      a;
        logic [63:0]      b;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!result_valid && issue_ready) else begin
            $display("outputs were not idle after reset");
            errors++;
        end

        send_op(exu_pkg::op_add, 0, 64'h0123_4567_89ab_cdef, 64'h1111_1111_1111_1111, "add", 0);
        send_op(exu_pkg::op_sub, 0, 64'd5, 64'd7, "sub_negative", 0);
        send_op(exu_pkg::op_add, 1, 64'h7fff_ffff, 64'd1, "addw_sign", 0);
        send_op(exu_pkg::op_sra, 1, 64'h8000_0000, 64'd4, "sraw_sign", 0);
        send_op(exu_pkg::op_sll, 0, 64'd3, 64'd65, "sll_mask6", 0);
        send_op(exu_pkg::op_sll, 1, 64'd3, 64'd33, "sllw_mask5", 0);
        send_op(exu_pkg::op_srl, 0, 64'hffff_0000_0000_0000, 64'd68, "srl_mask6", 0);
        send_op(exu_pkg::op_srl, 1, 64'hffff_ffff_8000_0000, 64'd35, "srlw_mask5", 0);
        send_op(exu_pkg::op_sra, 0, min64, 64'd63, "sra_full", 0);
        send_op(exu_pkg::op_and, 0, 64'hf0f0_ffff_0000_1234, 64'h0ff0_00ff_ff00_ffff, "and", 0);
        send_op(exu_pkg::op_or, 0, 64'hf0f0_0000_0000_1234, 64'h0ff0_00ff_ff00_0000, "or", 0);
        send_op(exu_pkg::op_xor, 1, 64'h1234_5678_9abc_def0, 64'hffff_ffff, "xorw", 0);
        send_op(exu_pkg::op_slt, 0, min64, 64'd1, "slt_min", 0);
        send_op(exu_pkg::op_sltu, 0, min64, 64'd1, "sltu_min", 0);
        send_op(exu_pkg::op_slt, 1, 64'h8000_0000, 64'd1, "sltw_min", 0);
        for (i = exu_pkg::op_beq; i <= exu_pkg::op_bgeu; i++) begin
            code = i;
            op   = exu_pkg::exu_op_e'(code);
            send_op(op, 0, min64, 64'd1, {op.name(), "_min_vs_one"}, 0);
            send_op(op, 0, 64'd5, 64'd5, {op.name(), "_equal"}, 0);
        end

        send_op(exu_pkg::op_mul, 0, -64'd3, 64'd7, "mul_negative", 0);
        send_op(exu_pkg::op_mul, 1, 64'h0001_0000, 64'h8000, "mulw_sign", 0);
        for (i = 0; i < 4; i++) begin
            send_op(exu_pkg::op_mul, 0, rand_bits(64), rand_bits(64), "mul_burst", i != 0);
        end
        send_op(exu_pkg::op_mul, 0, rand_bits(64), rand_bits(64), "mul_then_alu", 0);
        send_op(exu_pkg::op_add, 0, 64'd40, 64'd2, "alu_after_mul", 1);   // loses the bus once

        for (i = 0; i < 4; i++) begin
            code = exu_pkg::op_div + i;
            op   = exu_pkg::exu_op_e'(code);
            send_op(op, 0, 64'hdead_beef_0000_0123, 64'd0, {op.name(), "_by_zero"}, 0);
            send_op(op, 1, 64'h0000_0000_8765_4321, 64'd0, {op.name(), "w_by_zero"}, 0);
        end
        send_op(exu_pkg::op_div, 0, min64, '1, "div_overflow", 0);
        send_op(exu_pkg::op_rem, 0, min64, '1, "rem_overflow", 0);
        send_op(exu_pkg::op_div, 1, 64'h8000_0000, 64'hffff_ffff, "divw_overflow", 0);
        send_op(exu_pkg::op_rem, 1, 64'h8000_0000, 64'hffff_ffff, "remw_overflow", 0);
        send_op(exu_pkg::op_div, 0, -64'd7, 64'd2, "div_truncate", 0);
        send_op(exu_pkg::op_rem, 0, -64'd7, 64'd2, "rem_dividend_sign", 0);

        for (i = 0; i < n_random; i++) begin
            code = rand_bits(2);
            if (code == 5'd2) begin
                op = exu_pkg::op_mul;
            end else if (code == 5'd3) begin
                code = exu_pkg::op_div + rand_bits(2);
                op   = exu_pkg::exu_op_e'(code);
            end else begin
                code = rand_bits(4);
                op   = exu_pkg::exu_op_e'(code);
            end
            word = rand_bits(1);
            a    = rand_bits(64);
            b    = rand_bits(1) ? rand_bits(64) : rand_bits(12);   // small divisors too
            send_op(op, word, a, b, $sformatf("random_%s%s", op.name(), word ? "_w" : ""), 0);
        end

        @(posedge clk);
        issue_valid <= 1'b0;
        while (outstanding != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);   // catch a late extra result
        assert (retired == accepted) else begin
            $display("%0d issues were accepted but %0d results came back", accepted, retired);
            errors++;
        end
        $display("%0d errors, %0d accepted, %0d retired", errors, accepted, retired);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* verilog/exu_top.sv */
module exu_top #(
    parameter int mul_stages = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    input  exu_pkg::exu_issue_t  issue,
    output logic                 issue_ready,
    output logic                 result_valid,
    output exu_pkg::exu_result_t result
);

    logic                 alu_valid;
    logic                 mul_valid;
    logic                 div_valid;
    logic                 alu_grant;
    logic                 mul_grant;
    logic                 div_grant;
    logic                 alu_stalled;
    logic                 div_busy;
    exu_pkg::exu_result_t alu_res;
    exu_pkg::exu_result_t mul_res;
    exu_pkg::exu_result_t div_res;

    exu_alu u_alu (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .hold_valid  (alu_valid),
        .hold        (alu_res),
        .grant       (alu_grant),
        .stalled     (alu_stalled)
    );

    exu_mul #(
        .mul_stages (mul_stages)
    ) u_mul (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .hold_valid  (mul_valid),
        .hold        (mul_res),
        .grant       (mul_grant)
    );

    exu_div u_div (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .hold_valid  (div_valid),
        .hold        (div_res),
        .busy        (div_busy),
        .grant       (div_grant)
    );

    exu_writeback u_wb (
        .alu_valid    (alu_valid),
        .alu_res      (alu_res),
        .mul_valid    (mul_valid),
        .mul_res      (mul_res),
        .div_valid    (div_valid),
        .div_res      (div_res),
        .div_busy     (div_busy),
        .alu_stalled  (alu_stalled),
        .alu_grant    (alu_grant),
        .mul_grant    (mul_grant),
        .div_grant    (div_grant),
        .issue_ready  (issue_ready),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

/* verilog/exu_writeback.sv */
module exu_writeback (
    input  logic                 alu_valid,
    input  exu_pkg::exu_result_t alu_res,
    input  logic                 mul_valid,
    input  exu_pkg::exu_result_t mul_res,
    input  logic                 div_valid,
    input  exu_pkg::exu_result_t div_res,
    input  logic                 div_busy,
    input  logic                 alu_stalled,
    output logic                 alu_grant,
    output logic                 mul_grant,
    output logic                 div_grant,
    output logic                 issue_ready,
    output logic                 result_valid,
    output exu_pkg::exu_result_t result
);

    // fixed priority, divider first
    assign div_grant = div_valid;
    assign mul_grant = mul_valid && !div_valid;
    assign alu_grant = alu_valid && !div_valid && !mul_valid;

    assign result_valid = alu_valid || mul_valid || div_valid;

    always_comb begin
        if (div_valid) begin
            result = div_res;
        end else if (mul_valid) begin
            result = mul_res;
        end else begin
            result = alu_res;   // don't care when nothing is valid
        end
    end

    // divider running or holding, or an ALU result waiting for the bus
    assign issue_ready = !div_busy && !div_valid && !alu_stalled;

endmodule
